// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // phases of one serial frame, shared by rx and tx
  typedef enum logic [1:0] {
    uart_idle  = 2'd0,  // line high, waiting
    uart_start = 2'd1,  // start bit
    uart_data  = 2'd2,  // data bits, lsb first
    uart_stop  = 2'd3   // stop bit
  } uart_state_t;

  // payload bits per frame, no parity
  localparam int UART_DATA_BITS = 8;

endpackage

`default_nettype wire

// ==== tdc_ctrl_pkg.sv ====
`default_nettype none

package tdc_ctrl_pkg;

  // ascii command bytes from the host
  typedef enum logic [7:0] {
    cmd_boot   = 8'h64,  // 'd'
    cmd_pause  = 8'h73,  // 's'
    cmd_play   = 8'h70,  // 'p'
    cmd_status = 8'h3f   // '?'
  } cmd_t;

  // controller sequencing
  typedef enum logic [1:0] {
    st_idle        = 2'd0,  // decode commands
    st_enable_low  = 2'd1,  // tdc held off while it boots
    st_pulse_reset = 2'd2,  // one cycle of soft reset
    st_send_reply  = 2'd3   // wait for the transmitter
  } ctrl_state_t;

  // reply after a finished boot, 'k'
  localparam logic [7:0] ACK_BYTE = 8'h6b;

  // status reply is this base with
  // bit0 play, bit1 pause, bit2 tdc_enable
  localparam logic [7:0] STATUS_BASE = 8'h40;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] rx_data,
  output logic       new_rx_data
);

  import uart_pkg::*;

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(UART_DATA_BITS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(UART_DATA_BITS - 1);

  logic                      rx_meta;
  logic                      rx_sync;
  uart_state_t               state;
  logic [CNT_W-1:0]          clk_cnt;
  logic [IDX_W-1:0]          bit_idx;
  logic [UART_DATA_BITS-1:0] shift_q;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= uart_idle;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      new_rx_data <= 1'b0;
    end else begin
      new_rx_data <= 1'b0;  // strobe lasts one cycle
      case (state)
        uart_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync) begin
            state <= uart_start;  // falling edge seen
          end
        end
        uart_start: begin
          if (clk_cnt == CNT_MID) begin
            clk_cnt <= '0;
            state   <= rx_sync ? uart_idle : uart_data;  // glitch goes back to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_data: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            shift_q <= {rx_sync, shift_q[UART_DATA_BITS-1:1]};  // lsb arrives first
            if (bit_idx == IDX_LAST) begin
              state <= uart_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_stop: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            state   <= uart_idle;
            if (rx_sync) begin  // bad stop bit drops the frame
              rx_data     <= shift_q;
              new_rx_data <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= uart_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] tx_data,
  input  logic       new_tx_data,
  output logic       tx_busy,
  output logic       tx
);

  import uart_pkg::*;

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(UART_DATA_BITS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(UART_DATA_BITS - 1);

  uart_state_t               state;
  logic [CNT_W-1:0]          clk_cnt;
  logic [IDX_W-1:0]          bit_idx;
  logic [UART_DATA_BITS-1:0] shift_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= uart_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_busy <= 1'b0;
      tx      <= 1'b1;
    end else begin
      case (state)
        uart_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (new_tx_data) begin
            shift_q <= tx_data;
            tx      <= 1'b0;  // start bit from the next cycle on
            tx_busy <= 1'b1;
            state   <= uart_start;
          end
        end
        uart_start: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            tx      <= shift_q[0];
            state   <= uart_data;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_data: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_LAST) begin
              tx    <= 1'b1;  // stop bit
              state <= uart_stop;
            end else begin
              tx      <= shift_q[1];  // next bit before the shift lands
              shift_q <= shift_q >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_stop: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            tx_busy <= 1'b0;  // frame done, ready for the next byte
            state   <= uart_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= uart_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tdc_main_control.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdc_main_control #(
  parameter int BOOT_CYCLES = 170000
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  output logic [7:0] tx_data,
  output logic       new_tx_data,
  input  logic       tx_busy,
  output logic       tdc_enable,
  output logic       soft_reset,
  output logic       play,
  output logic       pause
);

  import tdc_ctrl_pkg::*;

  localparam int BOOT_W = $clog2(BOOT_CYCLES + 1);
  localparam logic [BOOT_W-1:0] BOOT_LAST = BOOT_W'(BOOT_CYCLES - 1);

  ctrl_state_t       state_d;
  ctrl_state_t       state_q;
  logic [BOOT_W-1:0] boot_cnt_d;
  logic [BOOT_W-1:0] boot_cnt_q;
  logic [7:0]        reply_d;
  logic [7:0]        reply_q;
  logic              play_d;
  logic              play_q;
  logic              pause_d;
  logic              pause_q;
  logic              tdc_enable_d;
  logic              tdc_enable_q;
  logic              soft_reset_d;
  logic              soft_reset_q;
  cmd_t              cmd;

  assign cmd        = cmd_t'(rx_data);
  assign tx_data    = reply_q;
  assign tdc_enable = tdc_enable_q;
  assign soft_reset = soft_reset_q;
  assign play       = play_q;
  assign pause      = pause_q;

  always_comb begin
    state_d      = state_q;
    boot_cnt_d   = boot_cnt_q;
    reply_d      = reply_q;
    play_d       = play_q;
    pause_d      = pause_q;
    tdc_enable_d = tdc_enable_q;
    soft_reset_d = 1'b0;  // only ever a single-cycle pulse
    new_tx_data  = 1'b0;

    case (state_q)
      st_idle: begin
        if (new_rx_data) begin
          case (cmd)
            cmd_boot: begin
              tdc_enable_d = 1'b0;  // power the tdc down for the boot interval
              boot_cnt_d   = '0;
              state_d      = st_enable_low;
            end
            cmd_pause: begin
              pause_d = 1'b1;
              play_d  = 1'b0;
            end
            cmd_play: begin
              play_d  = 1'b1;
              pause_d = 1'b0;
            end
            cmd_status: begin
              reply_d = STATUS_BASE | {5'b0, tdc_enable_q, pause_q, play_q};
              state_d = st_send_reply;
            end
            default: ;  // anything else is ignored
          endcase
        end
      end
      st_enable_low: begin
        if (boot_cnt_q == BOOT_LAST) begin
          tdc_enable_d = 1'b1;
          soft_reset_d = 1'b1;  // pulse lines up with the first enabled cycle
          state_d      = st_pulse_reset;
        end else begin
          boot_cnt_d = boot_cnt_q + 1'b1;
        end
      end
      st_pulse_reset: begin
        reply_d = ACK_BYTE;
        state_d = st_send_reply;
      end
      st_send_reply: begin
        if (!tx_busy) begin  // hold the reply until the tx is free
          new_tx_data = 1'b1;
          state_d     = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= st_idle;
      boot_cnt_q   <= '0;
      play_q       <= 1'b0;
      pause_q      <= 1'b0;
      tdc_enable_q <= 1'b0;
      soft_reset_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      boot_cnt_q   <= boot_cnt_d;
      play_q       <= play_d;
      pause_q      <= pause_d;
      tdc_enable_q <= tdc_enable_d;
      soft_reset_q <= soft_reset_d;
    end
  end

  always_ff @(posedge clk) begin
    reply_q <= reply_d;  // reply byte waiting for the transmitter
  end

endmodule

`default_nettype wire

// ==== tdc_host_link.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdc_host_link #(
  parameter int CLKS_PER_BIT = 868,
  parameter int BOOT_CYCLES  = 170000
) (
  input  logic clk,
  input  logic rst,
  input  logic rx,
  output logic tx,
  output logic tdc_enable,
  output logic soft_reset,
  output logic play,
  output logic pause
);

  logic [7:0] rx_data;
  logic       new_rx_data;
  logic [7:0] tx_data;
  logic       new_tx_data;
  logic       tx_busy;

  // host bytes in
  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk        (clk),
    .rst        (rst),
    .rx         (rx),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data)
  );

  // command decode and boot sequencing
  tdc_main_control #(
    .BOOT_CYCLES(BOOT_CYCLES)
  ) u_tdc_main_control (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data),
    .tx_data    (tx_data),
    .new_tx_data(new_tx_data),
    .tx_busy    (tx_busy),
    .tdc_enable (tdc_enable),
    .soft_reset (soft_reset),
    .play       (play),
    .pause      (pause)
  );

  // replies out
  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .clk        (clk),
    .rst        (rst),
    .tx_data    (tx_data),
    .new_tx_data(new_tx_data),
    .tx_busy    (tx_busy),
    .tx         (tx)
  );

endmodule

`default_nettype wire

// ==== tb_tdc_host_link.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_tdc_host_link;

  import uart_pkg::*;
  import tdc_ctrl_pkg::*;

  localparam int CLKS_PER_BIT   = 8;
  localparam int BOOT_CYCLES    = 200;
  localparam int NUM_BYTES      = 40;
  localparam int GAP_CYCLES     = 12 * CLKS_PER_BIT;  // long enough for a whole stray frame
  localparam int REPLY_LIMIT    = 15 * CLKS_PER_BIT + 20;
  localparam int BOOT_LIMIT     = BOOT_CYCLES + 4 * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = NUM_BYTES * (30 * CLKS_PER_BIT + BOOT_CYCLES + 50);
  localparam logic [31:0] SEED  = 32'h9cd67a2d;

  logic       clk;
  logic       rst;
  logic       rx;
  logic       tx;
  logic       tdc_enable;
  logic       soft_reset;
  logic       play;
  logic       pause;
  logic [7:0] frames[$];  // bytes decoded from tx
  logic       m_play;
  logic       m_pause;
  logic       m_en;
  logic       prev_en;
  int         errors = 0;
  int         checks = 0;
  int         cycle_cnt = 0;
  int         low_len = 0;
  int         last_low_len = 0;
  int         boot_done = 0;  // counts rising edges of tdc_enable

  tdc_host_link #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .BOOT_CYCLES (BOOT_CYCLES)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .tx        (tx),
    .tdc_enable(tdc_enable),
    .soft_reset(soft_reset),
    .play      (play),
    .pause     (pause)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks %0d errors %0d", checks, errors);
      $display("test failed");
      $finish;
    end
  end

  // soft_reset may only pulse in the first enabled cycle
  always @(posedge clk) begin
    if (rst) begin
      low_len <= 0;
      prev_en <= 1'b0;
    end else begin
      assert (soft_reset === (tdc_enable && !prev_en)) else begin
        errors++;
        $display("error: soft_reset got 0x%0h expected 0x%0h", soft_reset,
                 tdc_enable && !prev_en);
      end
      assert (!(play && pause)) else begin
        errors++;
        $display("play and pause were both high");
      end
      if (tdc_enable === 1'b0) begin
        low_len <= low_len + 1;
      end else if (!prev_en) begin
        last_low_len <= low_len;
        boot_done    <= boot_done + 1;
        low_len      <= 0;
      end
      prev_en <= tdc_enable;
    end
  end

  // decodes tx frames at mid-bit
  initial begin : tx_monitor
    logic [UART_DATA_BITS-1:0] data;
    int i;
    forever begin
      @(posedge clk);
      if (!rst && tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        assert (tx === 1'b0) else begin
          errors++;
          $display("tx start bit was not low at mid-bit");
        end
        for (i = 0; i < UART_DATA_BITS; i++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          data[i] = tx;  // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        assert (tx === 1'b1) else begin
          errors++;
          $display("tx stop bit was not high at mid-bit");
        end
        frames.push_back(data);
      end
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_bit("play", play, m_play);
    check_bit("pause", pause, m_pause);
    check_bit("tdc_enable", tdc_enable, m_en);
  endtask

  task automatic check_no_frame(input string when);
    checks++;
    assert (frames.size() == 0) else begin
      errors++;
      $display("unexpected tx frame seen %s", when);
      frames.delete();
    end
  endtask

  // start bit, data lsb first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [UART_DATA_BITS+1:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < UART_DATA_BITS + 2; i++) begin
      rx <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic expect_reply(input logic [7:0] exp, input string what);
    int waited;
    waited = 0;
    while (frames.size() == 0 && waited < REPLY_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (frames.size() != 0) else begin
      errors++;
      $display("no %s frame arrived on tx in time", what);
    end
    if (frames.size() != 0) begin
      check_byte(what, frames.pop_front(), exp);
    end
  endtask

  function automatic logic is_command(input logic [7:0] b);
    return b == cmd_boot || b == cmd_pause || b == cmd_play || b == cmd_status;
  endfunction

  function automatic logic [7:0] pick_byte();
    int unsigned r;
    logic [7:0] b;
    r = $urandom_range(9, 0);
    case (r)
      0, 1: b = cmd_boot;
      2, 3: b = cmd_pause;
      4, 5: b = cmd_play;
      6, 7: b = cmd_status;
      default: begin
        b = 8'($urandom());
        while (is_command(b)) begin
          b = 8'($urandom());  // keep unknown bytes unknown
        end
      end
    endcase
    return b;
  endfunction

  initial begin : stimulus
    logic [7:0] b;
    logic [7:0] status;
    logic       en_before;
    int         done_before;
    int         waited;
    int         n;
    rst     = 1'b1;
    rx      = 1'b1;
    m_play  = 1'b0;
    m_pause = 1'b0;
    m_en    = 1'b0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("tx", tx, 1'b1);
    check_bit("soft_reset", soft_reset, 1'b0);
    check_outputs();

    for (n = 0; n < NUM_BYTES; n++) begin
      b = pick_byte();
      check_no_frame("before a new command");
      if (b == cmd_boot) begin
        done_before = boot_done;
        en_before   = m_en;
        send_byte(b);
        waited = 0;
        while (boot_done == done_before && waited < BOOT_LIMIT) begin
          @(posedge clk);
          waited++;
        end
        assert (boot_done != done_before) else begin
          errors++;
          $display("boot sequence did not raise tdc_enable in time");
        end
        if (boot_done != done_before) begin
          checks++;
          if (en_before) begin
            assert (last_low_len == BOOT_CYCLES) else begin
              errors++;
              $display("error: tdc_enable low cycles got 0x%0h expected 0x%0h",
                       last_low_len, BOOT_CYCLES);
            end
          end else begin
            // low since reset, rise timed from the end of the command frame
            assert (waited >= BOOT_CYCLES - CLKS_PER_BIT &&
                    waited <= BOOT_CYCLES + CLKS_PER_BIT) else begin
              errors++;
              $display("tdc_enable did not rise one boot interval after the command");
            end
          end
        end
        m_en = 1'b1;
        expect_reply(ACK_BYTE, "ack reply");
      end else if (b == cmd_status) begin
        status = STATUS_BASE | {5'b0, m_en, m_pause, m_play};
        send_byte(b);
        expect_reply(status, "status reply");
      end else begin
        if (b == cmd_pause) begin
          m_pause = 1'b1;
          m_play  = 1'b0;
        end else if (b == cmd_play) begin
          m_play  = 1'b1;
          m_pause = 1'b0;
        end
        send_byte(b);
        repeat (GAP_CYCLES) @(posedge clk);
        check_no_frame("after a command with no reply");
      end
      check_outputs();
    end

    repeat (GAP_CYCLES) @(posedge clk);
    check_no_frame("at the end of the run");
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
uart_pkg.sv
tdc_ctrl_pkg.sv
uart_rx.sv
uart_tx.sv
tdc_main_control.sv
tdc_host_link.sv
tb_tdc_host_link.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_tdc_host_link
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --assert --timing -Wno-fatal
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
